//--- verif/wr_seq_vectors.txt
# test record: test <name> <last_idx> <ready level 1..8, 8 = always ready>
# then last_idx+1 descriptor lines, values in hex except the flag:
# <broadcast 0/1> <base_addr> <size> <offset> <loop_max>
test unicast_mix 2 5
0 00001000 040 00000040 0005
1 20000000 010 00000004 0003
0 3ffffff0 3ff 00000008 0000

test wrap_and_backpressure 4 3
0 fffffff0 100 00000010 0006
0 00400000 001 00000100 0009
1 00500000 080 00000020 0002
0 00000000 200 fffffffc 0004
1 7000abc0 3c0 00000001 0001

test full_ready 1 8
0 12345678 055 00000003 0007
0 00010000 2aa 00000010 0000

//--- all.f
common/wr_seq_pkg.sv
src/wr_loop_counter.sv
src/wr_desc_table.sv
src/wr_seq_fsm.sv
src/wr_addr_gen.sv
src/wr_dma_sequencer.sv
verif/tb_wr_dma_sequencer.sv

//--- run_sim.sh
#!/bin/sh
# build and run the write sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_wr_dma_sequencer \
  -f all.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- verif/tb_wr_dma_sequencer.sv
// testbench for the write sequencer: clock, vector reader, memory-side responder, checks
`timescale 1ns/1ns

module tb_wr_dma_sequencer import wr_seq_pkg::*; ();

  localparam int num_desc = 8;
  localparam int num_pu   = 4;
  localparam int idx_w    = 3;
  localparam int pu_w     = 2;

  logic              clk;
  logic              reset;
  logic              start;
  logic [idx_w-1:0]  last_idx;
  desc_wr_t          desc_wr;
  logic              busy;
  logic              done;
  logic              wr_ready;
  logic              wr_done;
  logic              wr_req;
  logic [addr_w-1:0] wr_addr;
  logic [pu_w-1:0]   wr_pu_id;
  logic [size_w-1:0] wr_req_size;

  logic [31:0] lfsr;
  wr_desc_t    exp_tab [num_desc];  // expected table of the running test
  string       test_name;
  int          n_desc;
  int          desc_pos;    // descriptor the responder is serving
  int          beats_seen;  // beats of that descriptor so far
  int          beats_total;
  int          level;       // wr_ready high when 3 random bits < level
  int          delay;
  bit          waiting;
  bit          done_due;
  bit          run_over;
  int          done_count;
  int          errors;
  int          tests;

  wr_dma_sequencer #(.num_desc(num_desc), .num_pu(num_pu)) dut0 (
    .clk(clk), .reset(reset), .start(start), .last_idx(last_idx), .desc_wr(desc_wr),
    .busy(busy), .done(done), .wr_ready(wr_ready), .wr_done(wr_done), .wr_req(wr_req),
    .wr_addr(wr_addr), .wr_pu_id(wr_pu_id), .wr_req_size(wr_req_size)
  );

  always #2 clk = ~clk;

  // **********************************************************************
  // helpers
  // **********************************************************************
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error in test %s: %s", test_name, what);
    errors++;
  endtask

  // skips comment and blank lines
  task automatic next_record_line(input int fd, output string line, output int got);
    int n;
    got = 0;
    n = 1;
    while (!got && n > 0) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != 8'h23)
        got = 1;
    end
  endtask

  // **********************************************************************
  // memory-side responder and beat checks
  // **********************************************************************
  always @(negedge clk) begin : responder
    int                r;
    logic [addr_w-1:0] exp_addr;
    logic [pu_w-1:0]   exp_pu;
    wr_desc_t          d;

    wr_done = 1'b0;
    if (waiting) begin
      if (delay == 0) begin
        wr_done = 1'b1;
        waiting = 1'b0;
      end else begin
        delay = delay - 1;
      end
    end
    take_bits(3, r);
    wr_ready = (r < level);
    #1;  // sample one ns before the rising edge
    if (!reset) begin
      if (done != done_due)
        report_mismatch("done", 32'(done_due), 32'(done));
      if (done)
        done_count++;
      if (done_due) begin
        run_over = 1'b1;
        if (busy)
          report_failure("busy still high after done");
      end
      done_due = 1'b0;
      if (wr_req && !wr_ready)
        report_failure("wr_req while wr_ready low");
      if (wr_req && desc_pos >= n_desc) begin
        report_failure("beat after the last descriptor");
      end else if (wr_req) begin
        d        = exp_tab[desc_pos];
        exp_addr = d.base_addr + addr_w'(beats_seen) * d.offset;
        exp_pu   = (d.mode == mode_broadcast) ? '0 : pu_w'(beats_seen % num_pu);
        if (beats_seen > int'(d.loop_max))
          report_failure("beat past loop_max");
        if (wr_addr != exp_addr)
          report_mismatch("wr_addr", exp_addr, wr_addr);
        if (wr_pu_id != exp_pu)
          report_mismatch("wr_pu_id", 32'(exp_pu), 32'(wr_pu_id));
        if (wr_req_size != d.size)
          report_mismatch("wr_req_size", 32'(d.size), 32'(wr_req_size));
        beats_seen++;
        beats_total++;
        if (beats_seen == int'(d.loop_max) + 1) begin
          take_bits(2, r);  // done after 0 to 3 idle cycles
          delay   = r;
          waiting = 1'b1;
        end
      end
      if (wr_done) begin
        if (desc_pos == n_desc - 1)
          done_due = 1'b1;
        desc_pos++;
        beats_seen = 0;
      end
    end
  end

  // **********************************************************************
  // test sequence
  // **********************************************************************
  initial begin : main
    int          fd;
    int          got;
    int          li;
    int          lvl;
    int          bc;
    int          cyc;
    int          i;
    int          exp_beats;
    int          beats_start;
    string       line;
    string       kw;
    logic [31:0] base;
    logic [31:0] offs;
    logic [9:0]  size;
    logic [15:0] lmax;

    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    last_idx = '0;
    desc_wr = '0;
    wr_ready = 1'b0;
    wr_done = 1'b0;
    lfsr = 32'h11e36b02;
    test_name = "reset";
    {n_desc, desc_pos, beats_seen, beats_total, level, delay} = '0;
    {waiting, done_due, run_over} = '0;
    {done_count, errors, tests} = '0;
    got = 0;

    fd = $fopen("verif/wr_seq_vectors.txt", "r");
    if (fd == 0)
      report_failure("cannot open verif/wr_seq_vectors.txt");
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    #1;
    if (wr_req || busy || done)
      report_failure("outputs not idle after reset");

    if (fd != 0)
      next_record_line(fd, line, got);
    while (got) begin
      if ($sscanf(line, "%s %s %d %d", kw, test_name, li, lvl) != 4 || kw != "test"
          || li >= num_desc) begin
        report_failure("bad test record in vector file");
        break;
      end
      exp_beats = 0;
      for (i = 0; i <= li; i++) begin
        next_record_line(fd, line, got);
        if (!got || $sscanf(line, "%d %h %h %h %h", bc, base, size, offs, lmax) != 5)
          report_failure("bad descriptor record in vector file");
        exp_tab[i].mode      = (bc != 0) ? mode_broadcast : mode_unicast;
        exp_tab[i].base_addr = base;
        exp_tab[i].size      = size;
        exp_tab[i].offset    = offs;
        exp_tab[i].loop_max  = lmax;
        exp_beats += int'(lmax) + 1;  // loop_max+1 beats each
        @(negedge clk);
        desc_wr.en   = 1'b1;
        desc_wr.idx  = 8'(i);
        desc_wr.desc = exp_tab[i];
      end
      @(negedge clk);
      desc_wr.en = 1'b0;

      n_desc      = li + 1;
      level       = lvl;
      desc_pos    = 0;
      beats_seen  = 0;
      beats_start = beats_total;
      done_count  = 0;
      run_over    = 1'b0;
      last_idx    = idx_w'(li);
      start       = 1'b1;
      @(negedge clk);
      start = 1'b0;
      #1;
      if (!busy)
        report_failure("busy did not rise after start");

      for (cyc = 0; cyc < 4000 && !run_over; cyc++)
        @(negedge clk);
      if (!run_over) begin
        report_failure("timeout while waiting for done");
        break;
      end
      if (beats_total - beats_start != exp_beats)
        report_mismatch("beats", 32'(exp_beats), 32'(beats_total - beats_start));
      tests++;
      repeat (3) @(negedge clk);  // idle gap, a stray done shows here
      if (done_count != 1)
        report_mismatch("done pulses", 32'd1, 32'(done_count));
      next_record_line(fd, line, got);
    end

    $display("tests=%0d beats=%0d errors=%0d", tests, beats_total, errors);
    if (errors == 0 && tests > 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- src/wr_dma_sequencer.sv
// write sequencer top: descriptor table, fsm, address gen, beat and index counters
`timescale 1ns/1ns

module wr_dma_sequencer import wr_seq_pkg::*; #(
  parameter  int num_desc = 8,
  parameter  int num_pu   = 4,
  localparam int idx_w    = (num_desc > 1) ? $clog2(num_desc) : 1,
  localparam int pu_w     = (num_pu > 1) ? $clog2(num_pu) : 1
) (
  input  logic              clk,
  input  logic              reset,
  // host side
  input  logic              start,
  input  logic [idx_w-1:0]  last_idx,
  input  desc_wr_t          desc_wr,
  output logic              busy,
  output logic              done,
  // memory side
  input  logic              wr_ready,
  input  logic              wr_done,
  output logic              wr_req,
  output logic [addr_w-1:0] wr_addr,
  output logic [pu_w-1:0]   wr_pu_id,
  output logic [size_w-1:0] wr_req_size
);

  // **********************************************************************
  // internal wiring
  // **********************************************************************
  wr_desc_t         cur_desc;
  logic [idx_w-1:0] cur_idx;
  logic [idx_w-1:0] last_idx_q;
  logic             start_ok;
  logic             load;
  logic             beat;
  logic             desc_next;
  logic             beat_last;
  logic             idx_last;

  assign start_ok    = start && !busy;  // ignored while running
  assign wr_req_size = cur_desc.size;

  // sampled once per run
  always_ff @(posedge clk) begin
    if (reset)
      last_idx_q <= '0;
    else if (start_ok)
      last_idx_q <= last_idx;
  end

  // **********************************************************************
  // instances
  // **********************************************************************
  wr_desc_table #(.num_desc(num_desc)) desc_table (
    .clk     (clk),
    .desc_wr (desc_wr),
    .rd_idx  (cur_idx),
    .rd_desc (cur_desc)
  );

  wr_seq_fsm seq_fsm (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .wr_ready  (wr_ready),
    .wr_done   (wr_done),
    .beat_last (beat_last),
    .idx_last  (idx_last),
    .load      (load),
    .beat      (beat),
    .desc_next (desc_next),
    .wr_req    (wr_req),
    .busy      (busy),
    .done      (done)
  );

  wr_addr_gen #(.num_pu(num_pu)) addr_gen (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .beat     (beat),
    .desc     (cur_desc),
    .wr_addr  (wr_addr),
    .wr_pu_id (wr_pu_id)
  );

  // beats within one descriptor
  wr_loop_counter #(.width(loop_w)) beat_counter (
    .clk       (clk),
    .reset     (reset),
    .clear     (load),
    .inc       (beat),
    .max_count (cur_desc.loop_max),
    .count     (),
    .last      (beat_last)
  );

  // table index, 0 up to last_idx
  wr_loop_counter #(.width(idx_w)) idx_counter (
    .clk       (clk),
    .reset     (reset),
    .clear     (start_ok),
    .inc       (desc_next),
    .max_count (last_idx_q),
    .count     (cur_idx),
    .last      (idx_last)
  );

  // table may only change between runs
  a_host_write_idle: assert property (
    @(posedge clk) disable iff (reset)
    desc_wr.en |-> !busy
  ) else $error("descriptor write while busy");

endmodule

//--- src/wr_addr_gen.sv
// write address register and round-robin processing-unit id
`timescale 1ns/1ns

module wr_addr_gen import wr_seq_pkg::*; #(
  parameter  int num_pu = 4,
  localparam int pu_w   = (num_pu > 1) ? $clog2(num_pu) : 1
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  logic              beat,
  input  wr_desc_t          desc,
  output logic [addr_w-1:0] wr_addr,
  output logic [pu_w-1:0]   wr_pu_id
);

  localparam logic [pu_w-1:0] pu_max = pu_w'(num_pu - 1);

  logic [pu_w-1:0] pu_count;

  // **********************************************************************
  // address
  // **********************************************************************
  always_ff @(posedge clk) begin
    if (reset)
      wr_addr <= '0;
    else if (load)
      wr_addr <= desc.base_addr;
    else if (beat)
      wr_addr <= wr_addr + desc.offset;  // next beat
  end

  // **********************************************************************
  // pu id
  // **********************************************************************
  wr_loop_counter #(
    .width     (pu_w)
  ) pu_counter (
    .clk       (clk),
    .reset     (reset),
    .clear     (load),  // restart at pu 0 per descriptor
    .inc       (beat),
    .max_count (pu_max),
    .count     (pu_count),
    .last      ()
  );

  // broadcast goes to pu 0
  assign wr_pu_id = (desc.mode == mode_broadcast) ? '0 : pu_count;

endmodule

//--- src/wr_seq_fsm.sv
// write sequencer state machine: idle, load, busy, wait for done
`timescale 1ns/1ns

module wr_seq_fsm import wr_seq_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic wr_ready,
  input  logic wr_done,
  input  logic beat_last,
  input  logic idx_last,
  output logic load,
  output logic beat,
  output logic desc_next,
  output logic wr_req,
  output logic busy,
  output logic done
);

  wr_state_t state;
  wr_state_t state_nxt;
  logic      stage;  // second cycle of st_load

  // **********************************************************************
  // outputs
  // **********************************************************************
  assign wr_req    = (state == st_busy) && wr_ready && !wr_done;
  assign beat      = wr_req;
  assign load      = (state == st_load) && stage;  // table data valid now
  assign desc_next = (state == st_wait_done) && wr_done;
  assign busy      = (state != st_idle);

  // **********************************************************************
  // next state
  // **********************************************************************
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start)
          state_nxt = st_load;
      end
      st_load: begin
        if (stage)
          state_nxt = st_busy;
      end
      st_busy: begin
        if (beat && beat_last)
          state_nxt = st_wait_done;
      end
      st_wait_done: begin
        if (wr_done)
          state_nxt = idx_last ? st_idle : st_load;
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      stage <= 1'b0;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      stage <= (state == st_load) && !stage;
      done  <= desc_next && idx_last;  // one cycle after final wr_done
    end
  end

  // st_busy ends with the last beat, no request right after it
  a_no_req_after_last: assert property (
    @(posedge clk) disable iff (reset)
    (beat && beat_last) |=> !wr_req
  ) else $error("wr_req after the last beat");

  a_done_no_req: assert property (
    @(posedge clk) disable iff (reset)
    done |-> !wr_req
  ) else $error("done together with wr_req");

endmodule

//--- src/wr_desc_table.sv
// descriptor memory with host write port and registered read port
`timescale 1ns/1ns

module wr_desc_table import wr_seq_pkg::*; #(
  parameter  int num_desc = 8,
  localparam int idx_w    = (num_desc > 1) ? $clog2(num_desc) : 1
) (
  input  logic             clk,
  input  desc_wr_t         desc_wr,
  input  logic [idx_w-1:0] rd_idx,
  output wr_desc_t         rd_desc
);

  // **********************************************************************
  // storage
  // **********************************************************************
  wr_desc_t mem [num_desc];

  logic [idx_w-1:0] wr_idx;

  // only the low index bits address this table
  assign wr_idx = desc_wr.idx[idx_w-1:0];

  // host port
  always_ff @(posedge clk) begin
    if (desc_wr.en)
      mem[wr_idx] <= desc_wr.desc;
  end

  // read side, one cycle behind rd_idx
  always_ff @(posedge clk) begin
    rd_desc <= mem[rd_idx];
  end

endmodule

//--- src/wr_loop_counter.sv
// wrapping up-counter with clear, runtime maximum and last-count flag
`timescale 1ns/1ns

module wr_loop_counter #(
  parameter int width = 16
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             inc,
  input  logic [width-1:0] max_count,
  output logic [width-1:0] count,
  output logic             last
);

  assign last = (count == max_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (inc) begin
      if (last)
        count <= '0;  // wrap
      else
        count <= count + width'(1);
    end
  end

  // max may move under a held count, but then only for one cycle
  a_count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    $stable(max_count) |-> (count <= max_count)
  ) else $error("counter above max_count");

endmodule

//--- common/wr_seq_pkg.sv
// widths, descriptor and host write structs, mode and state enums
package wr_seq_pkg;

  // **********************************************************************
  // widths
  // **********************************************************************
  localparam int unsigned addr_w = 32;
  localparam int unsigned size_w = 10;
  localparam int unsigned loop_w = 16;

  // **********************************************************************
  // descriptor
  // **********************************************************************
  typedef enum logic [1:0] {
    mode_unicast   = 2'd0,  // pu id rotates per beat
    mode_broadcast = 2'd2   // pu id stays at zero
  } wr_mode_t;

  // 92 bits, mode in the top bits
  typedef struct packed {
    wr_mode_t            mode;
    logic [addr_w-1:0]   base_addr;
    logic [size_w-1:0]   size;
    logic [addr_w-1:0]   offset;    // added after every beat
    logic [loop_w-1:0]   loop_max;  // beats minus one
  } wr_desc_t;

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_busy,
    st_wait_done
  } wr_state_t;

  // host table write, idx sized for the deepest table
  typedef struct packed {
    logic       en;
    logic [7:0] idx;
    wr_desc_t   desc;
  } desc_wr_t;

endpackage
